//--- Makefile
TOP = ex_stage_tb

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build folder and the log"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f ex_stage.f -Mdir obj_dir
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	@cat sim.log
	@grep -qx "=== PASS ===" sim.log

clean:
	rm -rf obj_dir sim.log

//--- ex_alu.sv
`timescale 1ns/1ps

module ex_alu (
	input  logic                 clk,
	input  logic                 rst_i,
	input  ex_pipe_pkg::ex_req_t req_i,
	output ex_pipe_pkg::ex_wb_t  wb_o
);
	import ex_isa_pkg::*;
	import ex_pipe_pkg::*;

	logic [XLEN-1:0]    result;
	logic [SHAMT_W-1:0] shamt;
	logic               lt_s;
	logic               lt_u;

	// Full 6-bit shift amount for 64-bit data
	assign shamt = req_i.op2[SHAMT_W-1:0];
	assign lt_s  = $signed(req_i.op1) < $signed(req_i.op2);
	assign lt_u  = req_i.op1 < req_i.op2;

	// --------------------------------------------------
	// Result select
	// --------------------------------------------------
	always_comb begin
		case (req_i.alu_op)
			ALU_ADD:  result = req_i.op1 + req_i.op2;
			ALU_SUB:  result = req_i.op1 - req_i.op2;
			ALU_SLL:  result = req_i.op1 << shamt;
			ALU_SLT:  result = {{(XLEN-1){1'b0}}, lt_s};
			ALU_SLTU: result = {{(XLEN-1){1'b0}}, lt_u};
			ALU_XOR:  result = req_i.op1 ^ req_i.op2;
			ALU_SRL:  result = req_i.op1 >> shamt;
			ALU_SRA:  result = $unsigned($signed(req_i.op1) >>> shamt);
			ALU_OR:   result = req_i.op1 | req_i.op2;
			ALU_AND:  result = req_i.op1 & req_i.op2;
			default:  result = '0;
		endcase
	end

	// --------------------------------------------------
	// Write-back register
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst_i) begin
			wb_o.valid <= 1'b0;
			wb_o.wr_en <= 1'b0;
		end else begin
			wb_o.valid <= req_i.valid;
			wb_o.wr_en <= req_i.valid & req_i.wr_en;
		end
		if (req_i.valid) begin
			wb_o.rd   <= req_i.rd;
			wb_o.data <= result;
		end
	end

endmodule

//--- ex_branch.sv
`timescale 1ns/1ps

module ex_branch (
	input  logic                  clk,
	input  logic                  rst_i,
	input  ex_pipe_pkg::ex_req_t  req_i,
	output ex_pipe_pkg::ex_jump_t jmp_o
);
	import ex_isa_pkg::*;
	import ex_pipe_pkg::*;

	logic            taken;
	logic [XLEN-1:0] target;

	assign target = req_i.jump_base + req_i.jump_offset;

	// --------------------------------------------------
	// Condition evaluation
	// --------------------------------------------------
	always_comb begin
		case (req_i.br_op)
			BR_EQ:     taken = req_i.op1 == req_i.op2;
			BR_NE:     taken = req_i.op1 != req_i.op2;
			BR_LT:     taken = $signed(req_i.op1) < $signed(req_i.op2);
			BR_GE:     taken = $signed(req_i.op1) >= $signed(req_i.op2);
			BR_LTU:    taken = req_i.op1 < req_i.op2;
			BR_GEU:    taken = req_i.op1 >= req_i.op2;
			BR_ALWAYS: taken = 1'b1;
			default:   taken = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			jmp_o.en <= 1'b0;
		end else begin
			jmp_o.en <= req_i.valid & taken;
		end
		// Not-taken requests report a zero address
		if (req_i.valid) begin
			jmp_o.addr <= taken ? target : '0;
		end
	end

endmodule

//--- ex_decode.sv
`timescale 1ns/1ps

module ex_decode (
	input  logic                               clk,
	input  logic                               rst_i,
	input  logic                               valid_i,
	input  ex_isa_pkg::inst_u                  inst_i,
	input  logic [ex_pipe_pkg::XLEN-1:0]       op1_i,
	input  logic [ex_pipe_pkg::XLEN-1:0]       op2_i,
	input  logic [ex_pipe_pkg::XLEN-1:0]       jump_base_i,
	input  logic [ex_pipe_pkg::XLEN-1:0]       jump_offset_i,
	input  logic                               wr_en_i,
	input  logic [ex_pipe_pkg::REG_ADDR_W-1:0] rd_i,
	output ex_pipe_pkg::ex_req_t               req_o
);
	import ex_isa_pkg::*;

	alu_op_e alu_op;
	br_op_e  br_op;

	// Shared funct3 map for OP and OP-IMM
	function automatic alu_op_e alu_decode(input logic [2:0] f3, input logic sub_en,
			input logic sra_en);
		alu_op_e op;
		op = ALU_NONE;
		case (f3)
			F3_ADD_SUB: op = sub_en ? ALU_SUB : ALU_ADD;
			F3_SLL:     op = ALU_SLL;
			F3_SLT:     op = ALU_SLT;
			F3_SLTU:    op = ALU_SLTU;
			F3_XOR:     op = ALU_XOR;
			F3_SR:      op = sra_en ? ALU_SRA : ALU_SRL;
			F3_OR:      op = ALU_OR;
			F3_AND:     op = ALU_AND;
		endcase
		return op;
	endfunction

	always_comb begin
		alu_op = ALU_NONE;
		br_op  = BR_NONE;
		case (inst_i.r.opcode)
			OPC_OP: alu_op = alu_decode(inst_i.r.funct3, inst_i.r.funct7[5], inst_i.r.funct7[5]);
			// SUB does not exist for immediates, only SRAI
			OPC_OP_IMM: alu_op = alu_decode(inst_i.i.funct3, 1'b0, inst_i.i.imm12[10]);
			OPC_BRANCH: begin
				case (inst_i.r.funct3)
					F3_BEQ:  br_op = BR_EQ;
					F3_BNE:  br_op = BR_NE;
					F3_BLT:  br_op = BR_LT;
					F3_BGE:  br_op = BR_GE;
					F3_BLTU: br_op = BR_LTU;
					F3_BGEU: br_op = BR_GEU;
					default: br_op = BR_NONE;
				endcase
			end
			OPC_JAL, OPC_JALR: begin
				alu_op = ALU_ADD;
				br_op  = BR_ALWAYS;
			end
			OPC_LUI, OPC_AUIPC: alu_op = ALU_ADD;
			default: begin
				alu_op = ALU_NONE;
				br_op  = BR_NONE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			req_o.valid <= 1'b0;
		end else begin
			req_o.valid <= valid_i;
		end
		if (valid_i) begin
			req_o.alu_op      <= alu_op;
			req_o.br_op       <= br_op;
			req_o.wr_en       <= wr_en_i;
			req_o.rd          <= rd_i;
			req_o.op1         <= op1_i;
			req_o.op2         <= op2_i;
			req_o.jump_base   <= jump_base_i;
			req_o.jump_offset <= jump_offset_i;
		end
	end

endmodule

//--- ex_isa_pkg.sv
package ex_isa_pkg;

	// --------------------------------------------------
	// Opcodes
	// --------------------------------------------------
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

	// ALU funct3
	localparam logic [2:0] F3_ADD_SUB = 3'b000;
	localparam logic [2:0] F3_SLL     = 3'b001;
	localparam logic [2:0] F3_SLT     = 3'b010;
	localparam logic [2:0] F3_SLTU    = 3'b011;
	localparam logic [2:0] F3_XOR     = 3'b100;
	localparam logic [2:0] F3_SR      = 3'b101;
	localparam logic [2:0] F3_OR      = 3'b110;
	localparam logic [2:0] F3_AND     = 3'b111;

	// Branch funct3
	localparam logic [2:0] F3_BEQ  = 3'b000;
	localparam logic [2:0] F3_BNE  = 3'b001;
	localparam logic [2:0] F3_BLT  = 3'b100;
	localparam logic [2:0] F3_BGE  = 3'b101;
	localparam logic [2:0] F3_BLTU = 3'b110;
	localparam logic [2:0] F3_BGEU = 3'b111;

	// --------------------------------------------------
	// Instruction word views
	// --------------------------------------------------
	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} inst_r_t;

	typedef struct packed {
		logic [11:0] imm12;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} inst_i_t;

	typedef union packed {
		inst_r_t r;
		inst_i_t i;
	} inst_u;

	typedef enum logic [3:0] {
		ALU_NONE, ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
		ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
	} alu_op_e;

	typedef enum logic [2:0] {
		BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU, BR_ALWAYS
	} br_op_e;

endpackage

//--- ex_pipe_pkg.sv
package ex_pipe_pkg;

	localparam int XLEN       = 64;
	localparam int SHAMT_W    = 6;
	localparam int REG_ADDR_W = 5;

	// --------------------------------------------------
	// Decode to ALU and branch unit
	// --------------------------------------------------
	typedef struct packed {
		logic                  valid;
		ex_isa_pkg::alu_op_e   alu_op;
		ex_isa_pkg::br_op_e    br_op;
		logic                  wr_en;
		logic [REG_ADDR_W-1:0] rd;
		logic [XLEN-1:0]       op1;
		logic [XLEN-1:0]       op2;
		logic [XLEN-1:0]       jump_base;
		logic [XLEN-1:0]       jump_offset;
	} ex_req_t;

	// Register write-back
	typedef struct packed {
		logic                  valid;
		logic                  wr_en;
		logic [REG_ADDR_W-1:0] rd;
		logic [XLEN-1:0]       data;
	} ex_wb_t;

	// Jump request to the fetch side
	typedef struct packed {
		logic            en;
		logic [XLEN-1:0] addr;
	} ex_jump_t;

endpackage

//--- ex_stage.f
ex_isa_pkg.sv
ex_pipe_pkg.sv
ex_decode.sv
ex_alu.sv
ex_branch.sv
ex_stage.sv
ex_stage_assert.sv
ex_stage_tb.sv

//--- ex_stage.sv
`timescale 1ns/1ps

module ex_stage (
	input  logic                               clk,
	input  logic                               rst_i,
	input  logic                               valid_i,
	input  logic [31:0]                        inst_i,
	input  logic [ex_pipe_pkg::XLEN-1:0]       op1_i,
	input  logic [ex_pipe_pkg::XLEN-1:0]       op2_i,
	input  logic [ex_pipe_pkg::XLEN-1:0]       jump_base_i,
	input  logic [ex_pipe_pkg::XLEN-1:0]       jump_offset_i,
	input  logic                               reg_wr_en_i,
	input  logic [ex_pipe_pkg::REG_ADDR_W-1:0] reg_wr_addr_i,
	output logic                               out_valid_o,
	output logic                               reg_wr_en_o,
	output logic [ex_pipe_pkg::REG_ADDR_W-1:0] reg_wr_addr_o,
	output logic [ex_pipe_pkg::XLEN-1:0]       reg_wr_data_o,
	output logic                               jump_en_o,
	output logic [ex_pipe_pkg::XLEN-1:0]       jump_addr_o
);
	import ex_pipe_pkg::*;

	ex_req_t  req;
	ex_wb_t   wb;
	ex_jump_t jmp;

	ex_decode u_decode (
		.clk           (clk),
		.rst_i         (rst_i),
		.valid_i       (valid_i),
		.inst_i        (inst_i),
		.op1_i         (op1_i),
		.op2_i         (op2_i),
		.jump_base_i   (jump_base_i),
		.jump_offset_i (jump_offset_i),
		.wr_en_i       (reg_wr_en_i),
		.rd_i          (reg_wr_addr_i),
		.req_o         (req)
	);

	// Both result units sit in the same pipeline slot
	ex_alu u_alu (
		.clk   (clk),
		.rst_i (rst_i),
		.req_i (req),
		.wb_o  (wb)
	);

	ex_branch u_branch (
		.clk   (clk),
		.rst_i (rst_i),
		.req_i (req),
		.jmp_o (jmp)
	);

	assign out_valid_o   = wb.valid;
	assign reg_wr_en_o   = wb.wr_en;
	assign reg_wr_addr_o = wb.rd;
	assign reg_wr_data_o = wb.data;
	assign jump_en_o     = jmp.en;
	assign jump_addr_o   = jmp.addr;

endmodule

//--- ex_stage_assert.sv
`timescale 1ns/1ps

module ex_stage_assert (
	input logic clk,
	input logic rst_i,
	input logic valid_i,
	input logic out_valid_o,
	input logic reg_wr_en_o,
	input logic jump_en_o
);

	// Jumps only come with a result
	jump_has_valid: assert property (@(posedge clk) disable iff (rst_i)
		jump_en_o |-> out_valid_o)
		else $error("jump_en_o high without out_valid_o");

	// Two stages, no more and no less
	// Requests taken in while in reset never come out
	two_cycle_latency: assert property (@(posedge clk) disable iff (rst_i)
		out_valid_o == ($past(valid_i, 2) && !$past(rst_i, 1) && !$past(rst_i, 2)))
		else $error("out_valid_o does not follow valid_i by 2 cycles");

	quiet_in_reset: assert property (@(posedge clk)
		rst_i |=> !reg_wr_en_o && !jump_en_o)
		else $error("write or jump enable high while in reset");

endmodule

bind ex_stage ex_stage_assert u_assert (
	.clk         (clk),
	.rst_i       (rst_i),
	.valid_i     (valid_i),
	.out_valid_o (out_valid_o),
	.reg_wr_en_o (reg_wr_en_o),
	.jump_en_o   (jump_en_o)
);

//--- ex_stage_tb.sv
`timescale 1ns/1ps

module ex_stage_tb;
	import ex_isa_pkg::*;
	import ex_pipe_pkg::*;

	typedef struct packed {
		logic [31:0]           cycle;
		logic                  wr_en;
		logic [REG_ADDR_W-1:0] rd;
		logic [XLEN-1:0]       data;
		logic                  jump;
		logic [XLEN-1:0]       addr;
	} expect_t;

	logic                  clk;
	logic                  rst_i;
	logic                  valid_i;
	logic [31:0]           inst_i;
	logic [XLEN-1:0]       op1_i, op2_i, jump_base_i, jump_offset_i;
	logic                  reg_wr_en_i;
	logic [REG_ADDR_W-1:0] reg_wr_addr_i;
	logic                  out_valid_o, reg_wr_en_o, jump_en_o;
	logic [REG_ADDR_W-1:0] reg_wr_addr_o;
	logic [XLEN-1:0]       reg_wr_data_o, jump_addr_o;

	logic [31:0] lfsr;
	expect_t     exp_q[$];
	expect_t     head;
	int          cyc, errors, sent, tests, mark_err, mark_sent;

	ex_stage UUT (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Galois LFSR, one step per bit
	function automatic logic [63:0] take_bits(input int n);
		logic [63:0] v;
		v = '0;
		for (int k = 0; k < n; k++) begin
			lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
			v = {v[62:0], lfsr[0]};
		end
		return v;
	endfunction

	// --------------------------------------------------
	// Reference model
	// --------------------------------------------------
	function automatic logic [XLEN-1:0] alu_ref(input logic [2:0] f3, input logic alt,
			input logic is_op, input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
		logic [5:0] sh;
		logic       lt_s;
		sh = b[5:0];
		// Signs differ, so the negative one is smaller
		lt_s = (a[63] != b[63]) ? a[63] : (a < b);
		case (f3)
			F3_ADD_SUB: return (alt && is_op) ? a - b : a + b;
			F3_SLL:     return a << sh;
			F3_SLT:     return XLEN'(lt_s);
			F3_SLTU:    return XLEN'(a < b);
			F3_XOR:     return a ^ b;
			F3_SR:      return alt ? (a >> sh) | (a[63] ? ~({XLEN{1'b1}} >> sh) : '0) : a >> sh;
			F3_OR:      return a | b;
			default:    return a & b;
		endcase
	endfunction

	function automatic expect_t model(input logic [31:0] inst, input logic [XLEN-1:0] a,
			input logic [XLEN-1:0] b, input logic [XLEN-1:0] base, input logic [XLEN-1:0] off);
		expect_t e;
		logic    lt_s;
		e = '0;
		lt_s = (a[63] != b[63]) ? a[63] : (a < b);
		case (inst[6:0])
			OPC_OP:     e.data = alu_ref(inst[14:12], inst[30], 1'b1, a, b);
			OPC_OP_IMM: e.data = alu_ref(inst[14:12], inst[30], 1'b0, a, b);
			OPC_BRANCH: begin
				case (inst[14:12])
					F3_BEQ:  e.jump = a == b;
					F3_BNE:  e.jump = !(a == b);
					F3_BLT:  e.jump = lt_s;
					F3_BGE:  e.jump = !lt_s;
					F3_BLTU: e.jump = a < b;
					F3_BGEU: e.jump = !(a < b);
					default: e.jump = 1'b0;
				endcase
			end
			OPC_JAL, OPC_JALR: begin
				e.data = a + b;
				e.jump = 1'b1;
			end
			OPC_LUI, OPC_AUIPC: e.data = a + b;
			default: e.data = '0;
		endcase
		e.addr = e.jump ? base + off : '0;
		return e;
	endfunction

	// --------------------------------------------------
	// Stimulus
	// --------------------------------------------------
	function automatic logic [31:0] make_inst(input int kind);
		logic [31:0] w;
		w = 32'(take_bits(32));
		case (kind)
			0: w = {1'b0, w[30], 5'b0, w[24:7], OPC_OP};
			1: w[6:0] = OPC_OP_IMM;
			2: w[6:0] = OPC_BRANCH;
			3: w[6:0] = (take_bits(1) != 0) ? OPC_JAL : OPC_JALR;
			4: w[6:0] = (take_bits(1) != 0) ? OPC_LUI : OPC_AUIPC;
			// Load and OP-32, both outside this stage
			default: w[6:0] = (take_bits(1) != 0) ? 7'b0000011 : 7'b0111011;
		endcase
		return w;
	endfunction

	task automatic send(input logic [31:0] inst, input logic [XLEN-1:0] a,
			input logic [XLEN-1:0] b);
		expect_t         e;
		logic [XLEN-1:0] base;
		logic [XLEN-1:0] off;
		base = take_bits(64);
		off  = take_bits(64);
		e = model(inst, a, b, base, off);
		e.wr_en = 1'(take_bits(1));
		e.rd    = 5'(take_bits(5));
		@(posedge clk);
		e.cycle = cyc;
		valid_i       <= 1'b1;
		inst_i        <= inst;
		op1_i         <= a;
		op2_i         <= b;
		jump_base_i   <= base;
		jump_offset_i <= off;
		reg_wr_en_i   <= e.wr_en;
		reg_wr_addr_i <= e.rd;
		exp_q.push_back(e);
		sent++;
	endtask

	task automatic issue(input int kind);
		logic [31:0]     inst;
		logic [XLEN-1:0] a;
		logic [XLEN-1:0] b;
		inst = make_inst(kind);
		a = take_bits(64);
		b = take_bits(64);
		// Immediate goes in as operand 2, sign extended
		if (kind == 1)
			b = {{52{inst[31]}}, inst[31:20]};
		else if (kind == 2 && take_bits(2) == 0)
			b = a;
		send(inst, a, b);
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(posedge clk);
			valid_i <= 1'b0;
		end
	endtask

	task automatic random_reqs(input int lo, input int span, input int count, input bit gaps);
		for (int n = 0; n < count; n++) begin
			issue(lo + int'(take_bits(3)) % span);
			if (gaps)
				idle(int'(take_bits(2)) % 3);
		end
	endtask

	task automatic drain();
		int waited;
		waited = 0;
		while (exp_q.size() != 0 && waited < 20) begin
			@(posedge clk);
			valid_i <= 1'b0;
			waited++;
		end
		if (exp_q.size() != 0) begin
			$display("Timeout: %0d results never reached the outputs", exp_q.size());
			errors++;
			exp_q.delete();
		end
	endtask

	task automatic mark();
		mark_err  = errors;
		mark_sent = sent;
	endtask

	task automatic report(input string name);
		tests++;
		$display("test %0d %s: %0d requests, %0d errors", tests, name, sent - mark_sent,
			errors - mark_err);
	endtask

	task automatic report_mismatch(input string name, input logic [63:0] exp,
			input logic [63:0] got);
		$display("[ERROR] t=%0t %s expected %h got %h", $time, name, exp, got);
		errors++;
	endtask

	// --------------------------------------------------
	// Output monitor, sampled mid-cycle
	// --------------------------------------------------
	always @(negedge clk) begin
		if (!rst_i) begin
			if (out_valid_o && exp_q.size() == 0) begin
				$display("[ERROR] t=%0t result came out with no request pending", $time);
				errors++;
			end else if (out_valid_o) begin
				head = exp_q.pop_front();
				if (cyc - int'(head.cycle) != 2)
					report_mismatch("latency", 64'd2, 64'(cyc - int'(head.cycle)));
				if (reg_wr_en_o !== head.wr_en)
					report_mismatch("reg_wr_en_o", 64'(head.wr_en), 64'(reg_wr_en_o));
				if (reg_wr_addr_o !== head.rd)
					report_mismatch("reg_wr_addr_o", 64'(head.rd), 64'(reg_wr_addr_o));
				if (reg_wr_data_o !== head.data)
					report_mismatch("reg_wr_data_o", head.data, reg_wr_data_o);
				if (jump_en_o !== head.jump)
					report_mismatch("jump_en_o", 64'(head.jump), 64'(jump_en_o));
				if (jump_addr_o !== head.addr)
					report_mismatch("jump_addr_o", head.addr, jump_addr_o);
			end else if (reg_wr_en_o !== 1'b0 || jump_en_o !== 1'b0) begin
				$display("[ERROR] t=%0t write or jump enable high in an idle cycle", $time);
				errors++;
			end
		end
		cyc++;
	end

	initial begin
		lfsr = 32'h584a_4582;
		cyc = 0;
		errors = 0;
		sent = 0;
		tests = 0;
		rst_i = 1'b1;
		// A writing JAL held through reset must be dropped
		valid_i = 1'b1;
		inst_i = {25'd0, OPC_JAL};
		op1_i = '0;
		op2_i = '0;
		jump_base_i = '0;
		jump_offset_i = '0;
		reg_wr_en_i = 1'b1;
		reg_wr_addr_i = '0;
		repeat (4) @(posedge clk);
		rst_i <= 1'b0;
		valid_i <= 1'b0;

		mark();
		idle(6);
		report("reset");
		mark();
		random_reqs(0, 1, 60, 1'b1);
		drain();
		report("register ALU");
		mark();
		// ADDI with bit 30 set
		send({12'h400, 5'd3, F3_ADD_SUB, 5'd4, OPC_OP_IMM}, take_bits(64), 64'd1024);
		random_reqs(1, 1, 60, 1'b1);
		drain();
		report("immediate ALU");
		mark();
		random_reqs(2, 1, 60, 1'b1);
		drain();
		report("branches");
		mark();
		random_reqs(3, 3, 40, 1'b1);
		drain();
		report("jumps and upper immediates");
		mark();
		random_reqs(0, 6, 50, 1'b0);
		drain();
		report("back-to-back");

		$display("%0d tests, %0d requests, %0d errors", tests, sent, errors);
		if (errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule
